/* hw/fifoBuffer.sv */
`timescale 1ns/1ps

module fifoBuffer
(
    input  logic            Clk,
    input  logic            arstN,
    input  rtFifoPkg::uopT  uop,
    input  rtFifoPkg::ptrT  regOut,   // Pointer from the register file
    input  rtFifoPkg::dataT txIn,
    input  rtFifoPkg::dataT rxIn,
    output rtFifoPkg::dataT txOut,
    output rtFifoPkg::dataT rxOut
);

    rtFifoPkg::dataT   ram [rtFifoPkg::RamWords];   // Receive half low, transmit high
    rtFifoPkg::ramAddrT ramAddr;
    rtFifoPkg::dataT   ramIn;
    rtFifoPkg::dataT   rdReg;                     // RAM read register
    logic              loadNow;
    logic              txLoad;                    // Delayed output strobes
    logic              rxLoad;

    assign ramAddr = {uop.fifoSel, regOut};
    assign ramIn   = uop.fifoSel ? txIn : rxIn;

    // A read, or a write into an empty FIFO, refreshes the head word
    assign loadNow = (uop.ramOp == rtFifoPkg::RamRead) ||
                     ((uop.ramOp == rtFifoPkg::RamWrite) &&
                      (uop.flagOp == rtFifoPkg::FlagInit));

    ////////////////////////////////////////////////////////////
    // Shared RAM with write-through read register

    always_ff @(posedge Clk)
    begin
        if (uop.ramOp == rtFifoPkg::RamWrite)
        begin
            ram[ramAddr] <= ramIn;
            rdReg        <= ramIn;                // Write data passes through
        end
        else
            rdReg <= ram[ramAddr];
    end

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            txLoad <= 1'b0;
            rxLoad <= 1'b0;
            txOut  <= '0;
            rxOut  <= '0;
        end
        else
        begin
            txLoad <= loadNow &&  uop.fifoSel;
            rxLoad <= loadNow && !uop.fifoSel;
            if (txLoad)
                txOut <= rdReg;
            if (rxLoad)
                rxOut <= rdReg;
        end
    end

endmodule

/* hw/fifoCtrl.sv */
`timescale 1ns/1ps

module fifoCtrl
(
    input  logic                   Clk,
    input  logic                   arstN,
    input  rtFifoPkg::fifoCmdT     txCmd,
    input  rtFifoPkg::fifoCmdT     rxCmd,
    input  rtFifoPkg::fifoStatusT  txStatus,
    input  rtFifoPkg::fifoStatusT  rxStatus,
    output rtFifoPkg::uopT         uop
);

    rtFifoPkg::fifoCmdT    cmd    [rtFifoPkg::NumFifos];  // Index 1 is transmit
    rtFifoPkg::fifoStatusT status [rtFifoPkg::NumFifos];

    logic [rtFifoPkg::NumFifos-1:0] rstQ;      // Delayed rst for edge detect
    logic [rtFifoPkg::NumFifos-1:0] rstPend;   // Pending command latches
    logic [rtFifoPkg::NumFifos-1:0] wrPend;
    logic [rtFifoPkg::NumFifos-1:0] rdPend;
    logic [rtFifoPkg::NumFifos-1:0] rstDone;   // Sequence completion strobes
    logic [rtFifoPkg::NumFifos-1:0] wrDone;
    logic [rtFifoPkg::NumFifos-1:0] rdDone;

    rtFifoPkg::ctrlStateT state;
    rtFifoPkg::ctrlStateT nextState;
    logic                 fifoSel;             // FIFO being served
    logic                 nextSel;
    logic                 selEmpty;

    assign cmd[0]    = rxCmd;
    assign cmd[1]    = txCmd;
    assign status[0] = rxStatus;
    assign status[1] = txStatus;
    assign selEmpty  = status[fifoSel].empty;

    ////////////////////////////////////////////////////////////
    // Command latches

    always_comb
    begin
        for (int i = 0; i < rtFifoPkg::NumFifos; i++)
        begin
            rstDone[i] = (state == rtFifoPkg::sRstWr) && (fifoSel == 1'(i));
            wrDone[i]  = (state == rtFifoPkg::sWrCnt) && (fifoSel == 1'(i));
            rdDone[i]  = (state == rtFifoPkg::sRdMem) && (fifoSel == 1'(i));
        end
    end

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            rstQ    <= '0;
            rstPend <= '1;  // Transmit reset queued behind the receive one
            wrPend  <= '0;
            rdPend  <= '0;
        end
        else
        begin
            for (int i = 0; i < rtFifoPkg::NumFifos; i++)
            begin
                rstQ[i] <= cmd[i].rst;
                if (rstQ[i] && !cmd[i].rst)          // Falling edge
                    rstPend[i] <= 1'b1;
                else if (rstDone[i])
                    rstPend[i] <= 1'b0;
                if (cmd[i].wr && !status[i].full)    // Refused while full
                    wrPend[i] <= 1'b1;
                else if (wrDone[i] || rstPend[i])    // Pending reset drops it
                    wrPend[i] <= 1'b0;
                if (cmd[i].rd && !status[i].empty)   // Refused while empty
                    rdPend[i] <= 1'b1;
                else if (rdDone[i] || rstPend[i])
                    rdPend[i] <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Sequencer with fixed priority arbiter

    always_comb
    begin
        nextState = state;
        nextSel   = fifoSel;
        case (state)
            rtFifoPkg::sIdle:
            begin
                if (rstPend[1])
                begin
                    nextState = rtFifoPkg::sRstCnt;
                    nextSel   = 1'b1;
                end
                else if (rstPend[0])
                begin
                    nextState = rtFifoPkg::sRstCnt;
                    nextSel   = 1'b0;
                end
                else if (wrPend[1])                  // Host write
                begin
                    nextState = rtFifoPkg::sWrMem;
                    nextSel   = 1'b1;
                end
                else if (rdPend[0])                  // Host read
                begin
                    nextState = rtFifoPkg::sRdPtr;
                    nextSel   = 1'b0;
                end
                else if (rdPend[1])                  // Line side last
                begin
                    nextState = rtFifoPkg::sRdPtr;
                    nextSel   = 1'b1;
                end
                else if (wrPend[0])
                begin
                    nextState = rtFifoPkg::sWrMem;
                    nextSel   = 1'b0;
                end
            end
            rtFifoPkg::sRstCnt: nextState = rtFifoPkg::sRstRd;
            rtFifoPkg::sRstRd:  nextState = rtFifoPkg::sRstWr;
            rtFifoPkg::sWrMem:  nextState = rtFifoPkg::sWrPtr;
            rtFifoPkg::sWrPtr:  nextState = rtFifoPkg::sWrCnt;
            rtFifoPkg::sRdPtr:  nextState = rtFifoPkg::sRdCnt;
            rtFifoPkg::sRdCnt:  nextState = rtFifoPkg::sRdMem;
            default:            nextState = rtFifoPkg::sIdle;   // Last cycles
        endcase
    end

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            state   <= rtFifoPkg::sRstCnt;   // Receive FIFO reset first
            fifoSel <= 1'b0;
        end
        else
        begin
            state   <= nextState;
            fifoSel <= nextSel;
        end
    end

    ////////////////////////////////////////////////////////////
    // Micro-operation decode

    always_comb
    begin
        uop.fifoSel = fifoSel;
        uop.regSel  = rtFifoPkg::RegCnt;
        uop.aluOp   = rtFifoPkg::AluHold;
        uop.ramOp   = rtFifoPkg::RamNone;
        uop.flagOp  = rtFifoPkg::FlagNone;
        case (state)
            rtFifoPkg::sRstCnt: uop.aluOp = rtFifoPkg::AluClr;
            rtFifoPkg::sRstRd:
            begin
                uop.regSel = rtFifoPkg::RegRdPtr;
                uop.aluOp  = rtFifoPkg::AluClr;
            end
            rtFifoPkg::sRstWr:
            begin
                uop.regSel = rtFifoPkg::RegWrPtr;
                uop.aluOp  = rtFifoPkg::AluClr;
                uop.flagOp = rtFifoPkg::FlagInit;
            end
            rtFifoPkg::sWrMem:
            begin
                uop.regSel = rtFifoPkg::RegWrPtr;
                uop.ramOp  = rtFifoPkg::RamWrite;
                // Init leaves an empty FIFO's flags as they are and
                // tells the buffer to load the output register
                if (selEmpty)
                    uop.flagOp = rtFifoPkg::FlagInit;
            end
            rtFifoPkg::sWrPtr:
            begin
                uop.regSel = rtFifoPkg::RegWrPtr;
                uop.aluOp  = rtFifoPkg::AluInc;
            end
            rtFifoPkg::sWrCnt:
            begin
                uop.aluOp  = rtFifoPkg::AluInc;      // Wrap to zero means full
                uop.flagOp = rtFifoPkg::FlagFull;
            end
            rtFifoPkg::sRdPtr:
            begin
                uop.regSel = rtFifoPkg::RegRdPtr;
                uop.aluOp  = rtFifoPkg::AluInc;
            end
            rtFifoPkg::sRdCnt:
            begin
                uop.aluOp  = rtFifoPkg::AluDec;
                uop.flagOp = rtFifoPkg::FlagEmpty;
            end
            rtFifoPkg::sRdMem:
            begin
                uop.regSel = rtFifoPkg::RegRdPtr;
                if (!selEmpty)                       // Fetch next head word
                    uop.ramOp = rtFifoPkg::RamRead;
            end
            default: ;
        endcase
    end

endmodule

/* hw/fifoFlags.sv */
`timescale 1ns/1ps

module fifoFlags
(
    input  logic                   Clk,
    input  logic                   arstN,
    input  rtFifoPkg::uopT         uop,
    input  logic                   zero,       // From the pointer file
    output rtFifoPkg::fifoStatusT  txStatus,
    output rtFifoPkg::fifoStatusT  rxStatus
);

    // Index 1 holds the transmit flags
    rtFifoPkg::fifoStatusT flagReg [rtFifoPkg::NumFifos];

    ////////////////////////////////////////////////////////////
    // Flag registers

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < rtFifoPkg::NumFifos; i++)
            begin
                flagReg[i].empty <= 1'b1;   // Empty and not full
                flagReg[i].full  <= 1'b0;
            end
        end
        else
        begin
            for (int i = 0; i < rtFifoPkg::NumFifos; i++)
            begin
                if (uop.fifoSel == 1'(i))
                begin
                    case (uop.flagOp)
                        rtFifoPkg::FlagInit:
                        begin
                            flagReg[i].empty <= 1'b1;
                            flagReg[i].full  <= 1'b0;
                        end
                        rtFifoPkg::FlagEmpty:         // After a read
                        begin
                            flagReg[i].empty <= zero;
                            flagReg[i].full  <= 1'b0;
                        end
                        rtFifoPkg::FlagFull:          // After a write
                        begin
                            flagReg[i].empty <= 1'b0;
                            flagReg[i].full  <= zero;
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    assign txStatus = flagReg[1];
    assign rxStatus = flagReg[0];

endmodule

/* hw/ptrFile.sv */
`timescale 1ns/1ps

module ptrFile
(
    input  logic            Clk,
    input  logic            arstN,
    input  rtFifoPkg::uopT  uop,
    output rtFifoPkg::ptrT  regOut,   // Old value of the selected register
    output logic            zero      // Operation result is zero
);

    // Count, read pointer and write pointer per FIFO
    rtFifoPkg::ptrT regFile [rtFifoPkg::NumFifos][rtFifoPkg::NumRegs];
    logic [1:0]     regIdx;
    rtFifoPkg::ptrT result;

    always_comb
    begin
        case (uop.regSel)
            rtFifoPkg::RegRdPtr: regIdx = 2'd1;
            rtFifoPkg::RegWrPtr: regIdx = 2'd2;
            default:             regIdx = 2'd0;   // Word counter
        endcase
    end

    assign regOut = regFile[uop.fifoSel][regIdx];

    ////////////////////////////////////////////////////////////
    // Increment, decrement and clear unit

    always_comb
    begin
        case (uop.aluOp)
            rtFifoPkg::AluClr: result = '0;
            rtFifoPkg::AluDec: result = regOut - rtFifoPkg::ptrT'(1);
            rtFifoPkg::AluInc: result = regOut + rtFifoPkg::ptrT'(1);
            default:           result = regOut;
        endcase
    end

    assign zero = (result == '0);   // Full after inc, empty after dec

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int f = 0; f < rtFifoPkg::NumFifos; f++)
                for (int r = 0; r < rtFifoPkg::NumRegs; r++)
                    regFile[f][r] <= '0;
        end
        else if (uop.aluOp != rtFifoPkg::AluHold)
            regFile[uop.fifoSel][regIdx] <= result;   // Write back
    end

endmodule

/* hw/rtFifo.sv */
`timescale 1ns/1ps

module rtFifo
(
    input  logic                   Clk,
    input  logic                   arstN,
    input  rtFifoPkg::fifoCmdT     txCmd,      // Host writes, line reads
    input  rtFifoPkg::fifoCmdT     rxCmd,      // Line writes, host reads
    input  rtFifoPkg::dataT        txIn,
    input  rtFifoPkg::dataT        rxIn,
    output rtFifoPkg::dataT        txOut,      // Head word of each FIFO
    output rtFifoPkg::dataT        rxOut,
    output rtFifoPkg::fifoStatusT  txStatus,
    output rtFifoPkg::fifoStatusT  rxStatus
);

    rtFifoPkg::uopT  uop;       // Current micro-operation
    rtFifoPkg::ptrT  regOut;    // Selected counter or pointer
    logic            zero;

    ////////////////////////////////////////////////////////////
    // Controller and datapath

    fifoCtrl uCtrl
    (
        .Clk      (Clk),
        .arstN    (arstN),
        .txCmd    (txCmd),
        .rxCmd    (rxCmd),
        .txStatus (txStatus),
        .rxStatus (rxStatus),
        .uop      (uop)
    );

    ptrFile uPtrFile
    (
        .Clk    (Clk),
        .arstN  (arstN),
        .uop    (uop),
        .regOut (regOut),
        .zero   (zero)
    );

    fifoBuffer uBuffer
    (
        .Clk    (Clk),
        .arstN  (arstN),
        .uop    (uop),
        .regOut (regOut),   // RAM pointer
        .txIn   (txIn),
        .rxIn   (rxIn),
        .txOut  (txOut),
        .rxOut  (rxOut)
    );

    fifoFlags uFlags
    (
        .Clk      (Clk),
        .arstN    (arstN),
        .uop      (uop),
        .zero     (zero),
        .txStatus (txStatus),
        .rxStatus (rxStatus)
    );

endmodule

/* hw/rtFifoPkg.sv */
package rtFifoPkg;

    ////////////////////////////////////////////////////////////
    // Sizes

    localparam int DataBits    = 8;                  // One FIFO word
    localparam int PtrBits     = 4;                  // 16 words per FIFO
    localparam int RamAddrBits = PtrBits + 1;        // FIFO select on top
    localparam int RamWords    = 2 ** RamAddrBits;   // Both halves of the RAM
    localparam int NumFifos    = 2;                  // Index 1 is transmit
    localparam int NumRegs     = 3;                  // Count, read and write pointer

    typedef logic [DataBits-1:0]    dataT;
    typedef logic [PtrBits-1:0]     ptrT;
    typedef logic [RamAddrBits-1:0] ramAddrT;

    ////////////////////////////////////////////////////////////
    // Micro-operation fields

    typedef enum logic [1:0] {
        RegCnt   = 2'b00,   // Word counter
        RegRdPtr = 2'b10,
        RegWrPtr = 2'b11
    } regSelT;

    typedef enum logic [1:0] {
        AluHold = 2'b00,    // No write back
        AluClr  = 2'b01,
        AluDec  = 2'b10,
        AluInc  = 2'b11
    } aluOpT;

    typedef enum logic [1:0] {
        RamNone  = 2'b00,
        RamRead  = 2'b10,
        RamWrite = 2'b11    // Also passes write data to the read register
    } ramOpT;

    typedef enum logic [1:0] {
        FlagNone  = 2'b00,
        FlagInit  = 2'b01,  // Empty set, full cleared
        FlagEmpty = 2'b10,  // Empty from zero detect
        FlagFull  = 2'b11   // Full from zero detect
    } flagOpT;

    // One controller cycle
    typedef struct packed {
        logic   fifoSel;    // 1 selects transmit
        regSelT regSel;
        aluOpT  aluOp;
        ramOpT  ramOp;
        flagOpT flagOp;
    } uopT;

    typedef struct packed {
        logic rst;          // Acts on falling edge
        logic wr;           // Single cycle pulses
        logic rd;
    } fifoCmdT;

    typedef struct packed {
        logic empty;
        logic full;
    } fifoStatusT;

    typedef enum logic [3:0] {
        sIdle, sRstCnt, sRstRd, sRstWr,
        sWrMem, sWrPtr, sWrCnt,
        sRdPtr, sRdCnt, sRdMem
    } ctrlStateT;

endpackage

/* verif/rtFifo_assert.sv */
`timescale 1ns/1ps

module rtFifoAssert
(
    input logic                  Clk,
    input logic                  arstN,
    input rtFifoPkg::fifoStatusT txStatus,
    input rtFifoPkg::fifoStatusT rxStatus,
    input rtFifoPkg::ctrlStateT  state
);

    int busyCycles;        // Cycles since the controller left idle
    int assertFails = 0;   // Number of failed assertions

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
            busyCycles <= 0;
        else if (state == rtFifoPkg::sIdle)
            busyCycles <= 0;
        else
            busyCycles <= busyCycles + 1;
    end

    ////////////////////////////////////////////////////////////
    // Flags and sequencing

    txFlagsExclusive: assert property (@(posedge Clk) disable iff (!arstN)
        !(txStatus.empty && txStatus.full))
        else
        begin
            assertFails++;
            $error("Transmit FIFO flagged empty and full together");
        end

    rxFlagsExclusive: assert property (@(posedge Clk) disable iff (!arstN)
        !(rxStatus.empty && rxStatus.full))
        else
        begin
            assertFails++;
            $error("Receive FIFO flagged empty and full together");
        end

    idleWithinLimit: assert property (@(posedge Clk) disable iff (!arstN)
        busyCycles < 20)
        else
        begin
            assertFails++;
            $error("Controller stayed away from idle for 20 cycles");
        end

endmodule

bind fifoCtrl rtFifoAssert uAssert
(
    .Clk      (Clk),
    .arstN    (arstN),
    .txStatus (txStatus),
    .rxStatus (rxStatus),
    .state    (state)
);

/* verif/tbRtFifo.sv */
`timescale 1ns/1ps

module tbRtFifo;

    localparam int Seed       = 32'h086d_0c04;
    localparam int ClkPeriod  = 40;
    localparam int SlotCycles = 24;                      // Pulse spacing and check point
    localparam int RandOps    = 400;                     // Random slots per FIFO
    localparam int DirOps     = 60;                      // Upper bound on directed slots
    localparam int Depth      = 2 ** rtFifoPkg::PtrBits;
    localparam int LimitNs    = (RandOps + DirOps) * SlotCycles * ClkPeriod * 11 / 10;

    logic                  Clk;
    logic                  arstN;
    rtFifoPkg::fifoCmdT    txCmd;
    rtFifoPkg::fifoCmdT    rxCmd;
    rtFifoPkg::dataT       txIn;
    rtFifoPkg::dataT       rxIn;
    rtFifoPkg::dataT       txOut;
    rtFifoPkg::dataT       rxOut;
    rtFifoPkg::fifoStatusT txStatus;
    rtFifoPkg::fifoStatusT rxStatus;

    // Circular model per FIFO, index 1 is transmit
    rtFifoPkg::dataT modelMem  [2][Depth];
    int              modelHead [2];
    int              modelCnt  [2];
    int              checkCount;
    int              errCount;
    int              testErrStart;                       // Error count when a test began

    rtFifo DUT
    (
        .Clk      (Clk),
        .arstN    (arstN),
        .txCmd    (txCmd),
        .rxCmd    (rxCmd),
        .txIn     (txIn),
        .rxIn     (rxIn),
        .txOut    (txOut),
        .rxOut    (rxOut),
        .txStatus (txStatus),
        .rxStatus (rxStatus)
    );

    always #(ClkPeriod / 2) Clk = ~Clk;

    ////////////////////////////////////////////////////////////
    // Helpers

    task automatic nextCycle();
        @(posedge Clk);
        #2;                                              // Drive and sample off the edge
    endtask

    task automatic checkValue(input string name, input logic [7:0] got, input logic [7:0] exp);
        checkCount++;
        assert (got === exp)
        else
        begin
            errCount++;
            $display("CHECK FAILED at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic checkFifo(input int f);
        rtFifoPkg::fifoStatusT st;
        rtFifoPkg::dataT       head;
        string                 pre;
        st   = (f == 1) ? txStatus : rxStatus;
        head = (f == 1) ? txOut : rxOut;
        pre  = (f == 1) ? "tx" : "rx";
        checkValue({pre, "Status.empty"}, {7'b0, st.empty}, {7'b0, modelCnt[f] == 0});
        checkValue({pre, "Status.full"}, {7'b0, st.full}, {7'b0, modelCnt[f] == Depth});
        if (modelCnt[f] > 0)                             // Head defined only when not empty
            checkValue({pre, "Out"}, head, modelMem[f][modelHead[f]]);
    endtask

    // Acceptance follows the flags at the time of the pulse
    task automatic modelStep(input int f, input logic wr, input logic rd, input rtFifoPkg::dataT d);
        logic wrOk;
        logic rdOk;
        wrOk = wr && (modelCnt[f] < Depth);              // Lost while full
        rdOk = rd && (modelCnt[f] > 0);                  // Lost while empty
        if (wrOk)
        begin
            modelMem[f][(modelHead[f] + modelCnt[f]) % Depth] = d;
            modelCnt[f]++;
        end
        if (rdOk)
        begin
            modelHead[f] = (modelHead[f] + 1) % Depth;
            modelCnt[f]--;
        end
    endtask

    // One set of same-cycle pulses, then check once everything settled
    task automatic runSlot(input logic txWr, input logic txRd, input logic rxWr, input logic rxRd);
        if (txWr)
            txIn = 8'($urandom);                         // Held until the next write
        if (rxWr)
            rxIn = 8'($urandom);
        txCmd = {1'b0, txWr, txRd};
        rxCmd = {1'b0, rxWr, rxRd};
        modelStep(1, txWr, txRd, txIn);
        modelStep(0, rxWr, rxRd, rxIn);
        nextCycle();
        txCmd = '0;
        rxCmd = '0;
        repeat (SlotCycles - 1)
            nextCycle();
        checkFifo(1);
        checkFifo(0);
    endtask

    task automatic pulseReset(input int f);
        if (f == 1)
            txCmd.rst = 1'b1;
        else
            rxCmd.rst = 1'b1;
        nextCycle();
        txCmd = '0;                                      // Falling edge here
        rxCmd = '0;
        modelCnt[f]  = 0;
        modelHead[f] = 0;
        repeat (SlotCycles - 1)
            nextCycle();
        checkFifo(1);
        checkFifo(0);
    endtask

    task automatic endTest(input string name);
        if (errCount == testErrStart)
            $display("Test %s: ok", name);
        else
            $display("Test %s: %0d wrong value(s)", name, errCount - testErrStart);
        testErrStart = errCount;
    endtask

    ////////////////////////////////////////////////////////////
    // Sequence of tests

    initial
    begin
        logic [3:0] r;
        Clk          = 1'b0;
        arstN        = 1'b0;
        txCmd        = '0;
        rxCmd        = '0;
        txIn         = '0;
        rxIn         = '0;
        checkCount   = 0;
        errCount     = 0;
        testErrStart = 0;
        modelHead    = '{0, 0};
        modelCnt     = '{0, 0};
        void'($urandom(Seed));
        repeat (4)
            @(posedge Clk);
        #2;
        arstN = 1'b1;
        repeat (SlotCycles)                              // Both soft reset sequences run
            nextCycle();
        checkFifo(1);
        checkFifo(0);
        endTest("reset");

        for (int i = 0; i < RandOps; i++)
        begin
            r = 4'($urandom);
            runSlot(r[0], r[1], r[2], r[3]);
        end
        endTest("random mix");

        runSlot(1'b1, 1'b0, 1'b1, 1'b0);                 // Words in both, only tx is reset
        runSlot(1'b1, 1'b0, 1'b1, 1'b0);
        pulseReset(1);
        endTest("soft reset");

        for (int i = 0; i <= Depth; i++)                 // Last write finds tx full
            runSlot(1'b1, 1'b0, 1'b0, 1'b0);
        for (int i = 0; i < Depth; i++)
            runSlot(1'b0, 1'b1, 1'b0, 1'b0);
        endTest("full and order");

        runSlot(1'b0, 1'b1, 1'b0, 1'b0);
        endTest("read while empty");

        runSlot(1'b1, 1'b0, 1'b0, 1'b0);
        runSlot(1'b1, 1'b0, 1'b0, 1'b0);
        runSlot(1'b1, 1'b1, 1'b1, 1'b0);                 // Host write with line side
        runSlot(1'b0, 1'b1, 1'b1, 1'b1);                 // Host read with line side
        endTest("same cycle");

        $display("Summary: %0d checks, %0d wrong, %0d assertion failures",
                 checkCount, errCount, DUT.uCtrl.uAssert.assertFails);
        if (errCount == 0 && DUT.uCtrl.uAssert.assertFails == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    initial
    begin
        #(LimitNs);
        $display("Watchdog expired after %0d ns with tests still running", LimitNs);
        $display("TB FAILED");
        $finish;
    end

endmodule

/* vlog.f */
hw/rtFifoPkg.sv
hw/fifoCtrl.sv
hw/ptrFile.sv
hw/fifoBuffer.sv
hw/fifoFlags.sv
hw/rtFifo.sv
verif/rtFifo_assert.sv
verif/tbRtFifo.sv
